//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- common/cache_pkg.sv
package cache_pkg;

    // cache geometry
    localparam int index_bits = 6;
    localparam int tag_bits   = 6;
    localparam int line_count = 64;

    // backing RAM covers address bits 13 to 2
    localparam int ram_words     = 4096;
    localparam int ram_addr_bits = $clog2(ram_words);

    localparam int unused_bits = cpu_pkg::xlen - tag_bits - index_bits - 2;

    // address split as seen by the cache
    typedef struct packed {
        logic [unused_bits-1:0] unused;
        logic [tag_bits-1:0]    tag;
        logic [index_bits-1:0]  index;
        logic [1:0]             off;
    } addr_fields_t;

    // raw word for the RAM, fields for the cache
    typedef union packed {
        logic [cpu_pkg::xlen-1:0] raw;
        addr_fields_t             f;
    } addr_u;

    // cache line write, used by refills and stores
    typedef struct packed {
        logic                     en;
        logic [index_bits-1:0]    index;
        logic [tag_bits-1:0]      tag;
        logic [cpu_pkg::xlen-1:0] data;
        logic [3:0]               be;
    } line_wr_t;

endpackage

//--- common/cpu_pkg.sv
package cpu_pkg;

    // data word width
    localparam int xlen = 32;

    // memory opcodes, loads first and stores after them
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LBU = 3'd1,
        LH  = 3'd2,
        LHU = 3'd3,
        LW  = 3'd4,
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
    } mem_op_e;

    // one load or store from the requester
    typedef struct packed {
        mem_op_e           op;
        logic [xlen-1:0]   addr;
        logic [xlen-1:0]   wdata;
    } mem_req_t;

    // load result back to the requester
    typedef struct packed {
        logic [xlen-1:0]   rdata;
        // set when served without a refill
        logic              hit;
    } mem_resp_t;

endpackage

//--- dcache/dcache.sv
`timescale 1ns/1ps

module dcache (
    input  logic                       clk,
    input  logic                       rst,
    input  cache_pkg::addr_u           lookup_addr_i,
    input  logic                       lookup_en_i,
    input  cache_pkg::line_wr_t        wr_i,
    output logic                       hit_o,
    output logic [cpu_pkg::xlen-1:0]   line_o
);

    logic [cache_pkg::tag_bits-1:0] tag_mem [cache_pkg::line_count];
    logic [cpu_pkg::xlen-1:0]       data_mem [cache_pkg::line_count];
    logic [cache_pkg::line_count-1:0] valid_q;

    logic [cache_pkg::index_bits-1:0] rd_index;
    logic [cache_pkg::tag_bits-1:0]   rd_tag;
    logic [cpu_pkg::xlen-1:0]         merged;

    assign rd_index = lookup_addr_i.f.index;
    assign rd_tag   = lookup_addr_i.f.tag;

    // combinational lookup
    assign hit_o  = lookup_en_i && valid_q[rd_index] && (tag_mem[rd_index] == rd_tag);
    assign line_o = data_mem[rd_index];

    // merge new bytes over the stored line
    always_comb begin
        merged = data_mem[wr_i.index];
        for (int b = 0; b < 4; b++) begin
            if (wr_i.be[b]) begin
                merged[b*8 +: 8] = wr_i.data[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_q <= '0;
        end else if (wr_i.en) begin
            valid_q[wr_i.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            tag_mem[wr_i.index]  <= wr_i.tag;
            data_mem[wr_i.index] <= merged;
        end
    end

    // partial writes only merge into a line already holding that tag
    assert property (@(posedge clk) disable iff (!rst)
        (wr_i.en && wr_i.be != 4'hf) |->
            (valid_q[wr_i.index] && tag_mem[wr_i.index] == wr_i.tag))
        else $error("partial line write to a line that missed");

endmodule

//--- dcache/load_align.sv
`timescale 1ns/1ps

module load_align (
    input  logic [cpu_pkg::xlen-1:0]  word_i,
    input  cpu_pkg::mem_op_e          op_i,
    input  logic [1:0]                off_i,
    output logic [cpu_pkg::xlen-1:0]  data_o
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // lane picked by the byte offset
    always_comb begin
        case (off_i)
            2'd0:    byte_lane = word_i[7:0];
            2'd1:    byte_lane = word_i[15:8];
            2'd2:    byte_lane = word_i[23:16];
            default: byte_lane = word_i[31:24];
        endcase
    end

    assign half_lane = off_i[1] ? word_i[31:16] : word_i[15:0];

    always_comb begin
        case (op_i)
            cpu_pkg::LB:  data_o = {{24{byte_lane[7]}}, byte_lane};
            cpu_pkg::LBU: data_o = {24'b0, byte_lane};
            cpu_pkg::LH:  data_o = {{16{half_lane[15]}}, half_lane};
            cpu_pkg::LHU: data_o = {16'b0, half_lane};
            // LW and the store codes see the whole word
            default:      data_o = word_i;
        endcase
    end

endmodule

//--- src/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic                      clk,
    input  logic                      re_i,
    input  logic                      we_i,
    input  cache_pkg::addr_u          addr_i,
    input  logic [cpu_pkg::xlen-1:0]  wdata_i,
    input  logic [3:0]                be_i,
    output logic [cpu_pkg::xlen-1:0]  rdata_o
);

    logic [cpu_pkg::xlen-1:0] mem [cache_pkg::ram_words];
    logic [cache_pkg::ram_addr_bits-1:0] word_addr;

    // word index from the raw address
    assign word_addr = addr_i.raw[cache_pkg::ram_addr_bits+1:2];

    // contents start cleared
    initial begin
        for (int i = 0; i < cache_pkg::ram_words; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    mem[word_addr][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    // registered read, output holds until the next read
    always_ff @(posedge clk) begin
        if (re_i) begin
            rdata_o <= mem[word_addr];
        end
    end

endmodule

//--- src/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid_i,
    input  cpu_pkg::mem_req_t   req_i,
    output logic                resp_valid_o,
    output cpu_pkg::mem_resp_t  resp_o,
    output logic                busy_o
);

    cache_pkg::addr_u         lookup_addr;
    logic                     lookup_en;
    cache_pkg::line_wr_t      line_wr;
    logic                     hit;
    logic [cpu_pkg::xlen-1:0] line_word;

    logic                     ram_re;
    logic                     ram_we;
    cache_pkg::addr_u         ram_addr;
    logic [cpu_pkg::xlen-1:0] ram_wdata;
    logic [3:0]               ram_be;
    logic [cpu_pkg::xlen-1:0] ram_rdata;

    logic [cpu_pkg::xlen-1:0] align_word;
    cpu_pkg::mem_op_e         align_op;
    logic [1:0]               align_off;
    logic [cpu_pkg::xlen-1:0] aligned;

    miss_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .hit_i         (hit),
        .line_i        (line_word),
        .ram_rdata_i   (ram_rdata),
        .aligned_i     (aligned),
        .lookup_addr_o (lookup_addr),
        .lookup_en_o   (lookup_en),
        .wr_o          (line_wr),
        .ram_re_o      (ram_re),
        .ram_we_o      (ram_we),
        .ram_addr_o    (ram_addr),
        .ram_wdata_o   (ram_wdata),
        .ram_be_o      (ram_be),
        .align_word_o  (align_word),
        .align_op_o    (align_op),
        .align_off_o   (align_off),
        .resp_valid_o  (resp_valid_o),
        .resp_o        (resp_o),
        .busy_o        (busy_o)
    );

    dcache u_dcache (
        .clk           (clk),
        .rst           (rst),
        .lookup_addr_i (lookup_addr),
        .lookup_en_i   (lookup_en),
        .wr_i          (line_wr),
        .hit_o         (hit),
        .line_o        (line_word)
    );

    load_align u_align (
        .word_i (align_word),
        .op_i   (align_op),
        .off_i  (align_off),
        .data_o (aligned)
    );

    data_ram u_ram (
        .clk     (clk),
        .re_i    (ram_re),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .be_i    (ram_be),
        .rdata_o (ram_rdata)
    );

endmodule

//--- src/miss_ctrl.sv
`timescale 1ns/1ps

module miss_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid_i,
    input  cpu_pkg::mem_req_t          req_i,
    input  logic                       hit_i,
    input  logic [cpu_pkg::xlen-1:0]   line_i,
    input  logic [cpu_pkg::xlen-1:0]   ram_rdata_i,
    input  logic [cpu_pkg::xlen-1:0]   aligned_i,
    output cache_pkg::addr_u           lookup_addr_o,
    output logic                       lookup_en_o,
    output cache_pkg::line_wr_t        wr_o,
    output logic                       ram_re_o,
    output logic                       ram_we_o,
    output cache_pkg::addr_u           ram_addr_o,
    output logic [cpu_pkg::xlen-1:0]   ram_wdata_o,
    output logic [3:0]                 ram_be_o,
    output logic [cpu_pkg::xlen-1:0]   align_word_o,
    output cpu_pkg::mem_op_e           align_op_o,
    output logic [1:0]                 align_off_o,
    output logic                       resp_valid_o,
    output cpu_pkg::mem_resp_t         resp_o,
    output logic                       busy_o
);

    typedef enum logic [1:0] {
        idle,
        wait_ram,
        fill
    } state_e;

    state_e state_q;

    cpu_pkg::mem_op_e         pend_op_q;
    cache_pkg::addr_u         pend_addr_q;
    logic [cpu_pkg::xlen-1:0] refill_q;

    cache_pkg::addr_u         req_addr;
    logic                     take;
    logic                     is_load;
    logic                     is_store;
    logic                     misaligned;
    logic [3:0]               st_be;
    logic [cpu_pkg::xlen-1:0] st_data;

    assign req_addr = req_i.addr;
    assign take     = req_valid_i && (state_q == idle);
    assign is_load  = req_i.op inside {cpu_pkg::LB, cpu_pkg::LBU, cpu_pkg::LH,
                                       cpu_pkg::LHU, cpu_pkg::LW};
    assign is_store = !is_load;

    assign misaligned = ((req_i.op inside {cpu_pkg::LH, cpu_pkg::LHU, cpu_pkg::SH})
                            && req_addr.f.off[0])
                     || ((req_i.op inside {cpu_pkg::LW, cpu_pkg::SW})
                            && req_addr.f.off != 2'b00);

    // byte enables and lane-replicated store data
    always_comb begin
        case (req_i.op)
            cpu_pkg::SB: begin
                st_be   = 4'b0001 << req_addr.f.off;
                st_data = {4{req_i.wdata[7:0]}};
            end
            cpu_pkg::SH: begin
                st_be   = 4'b0011 << req_addr.f.off;
                st_data = {2{req_i.wdata[15:0]}};
            end
            default: begin
                st_be   = 4'hf;
                st_data = req_i.wdata;
            end
        endcase
    end

    assign lookup_addr_o = req_addr;
    assign lookup_en_o   = take;

    assign ram_addr_o  = req_addr;
    assign ram_re_o    = take && is_load && !hit_i;
    assign ram_we_o    = take && is_store;
    assign ram_wdata_o = st_data;
    assign ram_be_o    = st_be;

    // refill in fill state, otherwise SW always and SB/SH on a hit
    always_comb begin
        if (state_q == fill) begin
            wr_o.en    = 1'b1;
            wr_o.index = pend_addr_q.f.index;
            wr_o.tag   = pend_addr_q.f.tag;
            wr_o.data  = refill_q;
            wr_o.be    = 4'hf;
        end else begin
            wr_o.en    = take && is_store && (req_i.op == cpu_pkg::SW || hit_i);
            wr_o.index = req_addr.f.index;
            wr_o.tag   = req_addr.f.tag;
            wr_o.data  = st_data;
            wr_o.be    = st_be;
        end
    end

    // aligner sees the refilled word during fill
    assign align_word_o = (state_q == fill) ? refill_q : line_i;
    assign align_op_o   = (state_q == fill) ? pend_op_q : req_i.op;
    assign align_off_o  = (state_q == fill) ? pend_addr_q.f.off : req_addr.f.off;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q      <= idle;
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= (take && is_load && hit_i) || (state_q == fill);
            case (state_q)
                idle:     if (ram_re_o) state_q <= wait_ram;
                wait_ram: state_q <= fill;
                default:  state_q <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ram_re_o) begin
            pend_op_q   <= req_i.op;
            pend_addr_q <= req_addr;
        end
        // RAM word lands here one edge after the read
        if (state_q == wait_ram) begin
            refill_q <= ram_rdata_i;
        end
        resp_o.rdata <= aligned_i;
        resp_o.hit   <= (state_q != fill);
    end

    assign busy_o = (state_q != idle);

    // requester has no back-pressure and must wait out a miss
    assert property (@(posedge clk) disable iff (!rst) req_valid_i |-> !busy_o)
        else $error("request strobe while busy");

    assert property (@(posedge clk) disable iff (!rst) req_valid_i |-> !misaligned)
        else $error("misaligned access, op %0d addr %h", req_i.op, req_i.addr);

endmodule

//--- tb.f
common/cpu_pkg.sv
common/cache_pkg.sv
dcache/load_align.sv
dcache/dcache.sv
src/data_ram.sv
src/miss_ctrl.sv
src/mem_stage.sv
tests/tb_clock.sv
tests/tb_mem_stage.sv

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // reset held low for four rising edges
    initial begin
        rst_o = 1'b0;
        repeat (4) @(posedge clk_o);
        rst_o <= 1'b1;
    end

endmodule

//--- tests/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;

    localparam int timeout_cycles  = 20;
    localparam int random_requests = 2000;

    logic                clk;
    logic                rst;
    logic                req_valid;
    cpu_pkg::mem_req_t   req;
    logic                resp_valid;
    cpu_pkg::mem_resp_t  resp;
    logic                busy;

    logic [31:0] lfsr_state;
    logic [7:0]  ram_model [16384];
    logic        shadow_valid [cache_pkg::line_count];
    logic [5:0]  shadow_tag [cache_pkg::line_count];
    int          hit_count;
    int          miss_count;

    tb_clock u_clock (
        .clk_o (clk),
        .rst_o (rst)
    );

    mem_stage u_dut (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid),
        .req_i        (req),
        .resp_valid_o (resp_valid),
        .resp_o       (resp),
        .busy_o       (busy)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // expected load result from the byte image of the RAM
    function automatic logic [31:0] predict_load(input cpu_pkg::mem_op_e op,
                                                 input logic [31:0] addr);
        logic [13:0] a;
        logic [7:0]  b;
        logic [15:0] h;
        a = addr[13:0];
        b = ram_model[a];
        h = {ram_model[a + 14'd1], ram_model[a]};
        case (op)
            cpu_pkg::LB:  return {{24{b[7]}}, b};
            cpu_pkg::LBU: return {24'b0, b};
            cpu_pkg::LH:  return {{16{h[15]}}, h};
            cpu_pkg::LHU: return {16'b0, h};
            default:      return {ram_model[a + 14'd3], ram_model[a + 14'd2], h};
        endcase
    endfunction

    task automatic end_with_fail();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping after the first error");
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("FAILED at %0t: resp_valid_o latency = %0d, expected %0d", $time, got, exp);
            end_with_fail();
        end
    endtask

    task automatic check_busy(input logic exp);
        if (busy !== exp) begin
            $display("FAILED at %0t: busy_o = %b, expected %b", $time, busy, exp);
            end_with_fail();
        end
    endtask

    task automatic check_data(input logic [cpu_pkg::xlen-1:0] exp);
        logic [cpu_pkg::xlen-1:0] got;
        int n;
        n = 0;
        while (!resp_valid) begin
            @(negedge clk);
            n++;
            if (n > timeout_cycles) begin
                $display("ERROR at %0t: no load response arrived for the data check", $time);
                end_with_fail();
            end
        end
        got = resp.rdata;
        if (got !== exp) begin
            $display("FAILED at %0t: resp_o.rdata = %h, expected %h", $time, got, exp);
            end_with_fail();
        end
    endtask

    task automatic check_hit(input logic exp);
        cpu_pkg::mem_resp_t got;
        int n;
        n = 0;
        while (!resp_valid) begin
            @(negedge clk);
            n++;
            if (n > timeout_cycles) begin
                $display("ERROR at %0t: no load response arrived for the hit check", $time);
                end_with_fail();
            end
        end
        got = resp;
        if (got.hit !== exp) begin
            $display("FAILED at %0t: resp_o.hit = %b, expected %b", $time, got.hit, exp);
            end_with_fail();
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy) begin
            @(negedge clk);
            n++;
            if (n > timeout_cycles) begin
                $display("ERROR at %0t: busy_o stayed high", $time);
                end_with_fail();
            end
        end
    endtask

    task automatic apply_store(input cpu_pkg::mem_op_e op, input logic [31:0] addr,
                               input logic [31:0] wdata);
        logic [13:0] a;
        a = addr[13:0];
        ram_model[a] = wdata[7:0];
        if (op != cpu_pkg::SB) begin
            ram_model[a + 14'd1] = wdata[15:8];
        end
        // only a full word claims the line
        if (op == cpu_pkg::SW) begin
            ram_model[a + 14'd2] = wdata[23:16];
            ram_model[a + 14'd3] = wdata[31:24];
            shadow_valid[addr[7:2]] = 1'b1;
            shadow_tag[addr[7:2]]   = addr[13:8];
        end
    endtask

    task automatic issue(input cpu_pkg::mem_op_e op, input logic [31:0] addr,
                         input logic [31:0] wdata);
        cpu_pkg::mem_req_t r;
        logic              exp_hit;
        logic [31:0]       exp_data;
        int                lat;
        r.op     = op;
        r.addr   = addr;
        r.wdata  = wdata;
        exp_hit  = shadow_valid[addr[7:2]] && (shadow_tag[addr[7:2]] == addr[13:8]);
        exp_data = predict_load(op, addr);
        wait_idle();
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        // strobe edge
        @(posedge clk);
        req_valid <= 1'b0;
        if (op inside {cpu_pkg::SB, cpu_pkg::SH, cpu_pkg::SW}) begin
            apply_store(op, addr, wdata);
            @(negedge clk);
            if (resp_valid) begin
                $display("ERROR at %0t: a store produced a response", $time);
                end_with_fail();
            end
            check_busy(1'b0);
        end else begin
            lat = 0;
            do begin
                @(negedge clk);
                lat++;
                if (lat > timeout_cycles) begin
                    $display("ERROR at %0t: load to %h got no response", $time, addr);
                    end_with_fail();
                end
                // a miss keeps busy high until the response cycle
                check_busy(!exp_hit && lat < 3);
            end while (!resp_valid);
            check_latency(lat, exp_hit ? 1 : 3);
            check_data(exp_data);
            check_hit(exp_hit);
            if (exp_hit) begin
                hit_count++;
            end else begin
                miss_count++;
                shadow_valid[addr[7:2]] = 1'b1;
                shadow_tag[addr[7:2]]   = addr[13:8];
            end
        end
    endtask

    task automatic load_all_lanes(input logic [31:0] base);
        for (int off = 0; off < 4; off++) begin
            issue(cpu_pkg::LB, base + 32'(off), '0);
            issue(cpu_pkg::LBU, base + 32'(off), '0);
        end
        issue(cpu_pkg::LH, base, '0);
        issue(cpu_pkg::LHU, base, '0);
        issue(cpu_pkg::LH, base + 32'd2, '0);
        issue(cpu_pkg::LHU, base + 32'd2, '0);
        issue(cpu_pkg::LW, base, '0);
    endtask

    initial begin
        logic [31:0]      r;
        logic [31:0]      addr;
        cpu_pkg::mem_op_e op;
        int               n;
        req_valid  = 1'b0;
        req        = '0;
        lfsr_state = 32'ha302_d55a;
        hit_count  = 0;
        miss_count = 0;
        for (int i = 0; i < 16384; i++) begin
            ram_model[i] = 8'h00;
        end
        for (int i = 0; i < cache_pkg::line_count; i++) begin
            shadow_valid[i] = 1'b0;
            shadow_tag[i]   = '0;
        end

        n = 0;
        while (rst !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > timeout_cycles) begin
                $display("ERROR: reset was never released");
                end_with_fail();
            end
        end

        // cold misses, then the same words again as hits
        for (int pass = 0; pass < 2; pass++) begin
            issue(cpu_pkg::LW, 32'h000, '0);
            issue(cpu_pkg::LW, 32'h004, '0);
            issue(cpu_pkg::LW, 32'h0f8, '0);
            issue(cpu_pkg::LW, 32'h3fc, '0);
        end

        issue(cpu_pkg::SW, 32'h104, 32'hdead_beef);
        issue(cpu_pkg::LW, 32'h104, '0);

        // byte stores on a missing line, then halfword and byte merges on a hit
        issue(cpu_pkg::SB, 32'h080, 32'h0000_0081);
        issue(cpu_pkg::SB, 32'h081, 32'h0000_007f);
        issue(cpu_pkg::SB, 32'h082, 32'h0000_00c3);
        issue(cpu_pkg::SB, 32'h083, 32'h0000_0005);
        load_all_lanes(32'h080);
        issue(cpu_pkg::SH, 32'h082, 32'h0000_8a5c);
        issue(cpu_pkg::SH, 32'h080, 32'h0000_1234);
        issue(cpu_pkg::SB, 32'h081, 32'h0000_00f0);
        load_all_lanes(32'h080);

        // same index, different tags
        issue(cpu_pkg::LW, 32'h200, '0);
        issue(cpu_pkg::LW, 32'h200, '0);
        issue(cpu_pkg::LW, 32'h600, '0);
        issue(cpu_pkg::LW, 32'h200, '0);

        hit_count  = 0;
        miss_count = 0;
        for (int i = 0; i < random_requests; i++) begin
            r    = rand_bits(3);
            op   = cpu_pkg::mem_op_e'(r[2:0]);
            addr = rand_bits(10);
            if (op inside {cpu_pkg::LH, cpu_pkg::LHU, cpu_pkg::SH}) begin
                addr[0] = 1'b0;
            end else if (op inside {cpu_pkg::LW, cpu_pkg::SW}) begin
                addr[1:0] = 2'b00;
            end
            issue(op, addr, rand_bits(32));
        end

        if (hit_count > 0 && miss_count > 0) begin
            $display("random run: %0d hits, %0d misses", hit_count, miss_count);
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("ERROR: the random run did not see both hits and misses");
            end_with_fail();
        end
    end

endmodule
